//--- hw/exe_pkg.sv
// execute slice definitions
package exe_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(DATA_W);
    localparam int SEL_W      = 3;
    localparam int OP_W       = 8;

    typedef enum logic [SEL_W-1:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_ARITH = 3'd3,
        SEL_MOVE  = 3'd4,
        SEL_MULT  = 3'd5
    } alu_sel_t;

    // function field style codes
    typedef enum logic [OP_W-1:0] {
        OP_SLL  = 8'h00,
        OP_SRL  = 8'h02,
        OP_SRA  = 8'h03,
        OP_MFHI = 8'h10,
        OP_MTHI = 8'h11,
        OP_MFLO = 8'h12,
        OP_MTLO = 8'h13,
        OP_MULT = 8'h18,
        OP_ADD  = 8'h20,
        OP_SUB  = 8'h22,
        OP_AND  = 8'h24,
        OP_OR   = 8'h25,
        OP_XOR  = 8'h26,
        OP_NOR  = 8'h27,
        OP_SLT  = 8'h2a
    } alu_op_t;

    typedef struct packed {
        alu_sel_t              alu_sel;
        alu_op_t               alu_op;
        logic [DATA_W-1:0]     reg1;
        logic [DATA_W-1:0]     reg2;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] wd;
        logic                  mt_hi;
        logic                  mt_lo;
        logic [1:0]            mf_hi_lo; // {mfhi, mflo}
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '{
        alu_sel:  SEL_NOP,
        alu_op:   OP_SLL,
        reg1:     '0,
        reg2:     '0,
        wreg:     1'b0,
        wd:       '0,
        mt_hi:    1'b0,
        mt_lo:    1'b0,
        mf_hi_lo: 2'b00
    };

endpackage

//--- hw/id_ex_if.sv
// decode to execute bus
`timescale 1ns/1ps

interface id_ex_if
    import exe_pkg::*;
();

    alu_sel_t              alu_sel;
    alu_op_t               alu_op;
    logic [DATA_W-1:0]     reg1;
    logic [DATA_W-1:0]     reg2;
    logic                  wreg;
    logic [REG_ADDR_W-1:0] wd;
    logic                  mt_hi;
    logic                  mt_lo;
    logic [1:0]            mf_hi_lo; // bit 1 reads hi, bit 0 reads lo

    modport producer (
        output alu_sel, alu_op, reg1, reg2, wreg, wd, mt_hi, mt_lo, mf_hi_lo
    );

    modport consumer (
        input  alu_sel, alu_op, reg1, reg2, wreg, wd, mt_hi, mt_lo, mf_hi_lo
    );

endinterface

//--- hw/id_ex_reg.sv
// decode to execute pipeline register
`timescale 1ns/1ps

module id_ex_reg
    import exe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  stall_i,

    input  alu_sel_t              id_alu_sel_i,
    input  alu_op_t               id_alu_op_i,
    input  logic [DATA_W-1:0]     id_reg1_i,
    input  logic [DATA_W-1:0]     id_reg2_i,
    input  logic                  id_wreg_i,
    input  logic [REG_ADDR_W-1:0] id_wd_i,
    input  logic                  id_mt_hi_i,
    input  logic                  id_mt_lo_i,

    id_ex_if.producer             ex_o
);

    id_ex_t d;
    id_ex_t q;

    always_comb begin
        d.alu_sel  = id_alu_sel_i;
        d.alu_op   = id_alu_op_i;
        d.reg1     = id_reg1_i;
        d.reg2     = id_reg2_i;
        d.wreg     = id_wreg_i;
        d.wd       = id_wd_i;
        d.mt_hi    = id_mt_hi_i;
        d.mt_lo    = id_mt_lo_i;
        d.mf_hi_lo = {id_alu_op_i == OP_MFHI, id_alu_op_i == OP_MFLO};
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q <= ID_EX_BUBBLE;
        end else if (flush_i) begin
            q <= ID_EX_BUBBLE; // flush wins over stall
        end else if (!stall_i) begin
            q <= d;
        end
    end

    assign ex_o.alu_sel  = q.alu_sel;
    assign ex_o.alu_op   = q.alu_op;
    assign ex_o.reg1     = q.reg1;
    assign ex_o.reg2     = q.reg2;
    assign ex_o.wreg     = q.wreg;
    assign ex_o.wd       = q.wd;
    assign ex_o.mt_hi    = q.mt_hi;
    assign ex_o.mt_lo    = q.mt_lo;
    assign ex_o.mf_hi_lo = q.mf_hi_lo;

    // a move to hi/lo never also targets a gpr
    a_mt_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ex_o.mt_hi, ex_o.mt_lo, ex_o.wreg}))
        else $error("mt_hi/mt_lo/wreg set together");

endmodule

//--- hw/hilo_regs.sv
// hi and lo special registers
`timescale 1ns/1ps

module hilo_regs
    import exe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              hi_we_i,
    input  logic              lo_we_i,
    input  logic [DATA_W-1:0] hi_wdata_i,
    input  logic [DATA_W-1:0] lo_wdata_i,
    output logic [DATA_W-1:0] hi_rdata_o,
    output logic [DATA_W-1:0] lo_rdata_o
);

    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_we_i) hi_q <= hi_wdata_i;
            if (lo_we_i) lo_q <= lo_wdata_i;
        end
    end

    assign hi_rdata_o = hi_q;
    assign lo_rdata_o = lo_q;

    a_we_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown({hi_we_i, lo_we_i}))
        else $error("hi/lo write enable unknown");

endmodule

//--- hw/exe_unit.sv
// execute datapath and writeback register
`timescale 1ns/1ps

module exe_unit
    import exe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,

    id_ex_if.consumer             ex_i,

    input  logic [DATA_W-1:0]     hi_rdata_i,
    input  logic [DATA_W-1:0]     lo_rdata_i,
    output logic                  hi_we_o,
    output logic                  lo_we_o,
    output logic [DATA_W-1:0]     hi_wdata_o,
    output logic [DATA_W-1:0]     lo_wdata_o,

    output logic                  wb_wreg_o,
    output logic [REG_ADDR_W-1:0] wb_wd_o,
    output logic [DATA_W-1:0]     wb_wdata_o
);

    logic [SHAMT_W-1:0]         shamt;
    logic [DATA_W-1:0]          logic_res;
    logic [DATA_W-1:0]          shift_res;
    logic [DATA_W-1:0]          arith_res;
    logic [DATA_W-1:0]          move_res;
    logic [DATA_W-1:0]          result;
    logic signed [2*DATA_W-1:0] prod;
    logic                       is_mult;
    logic                       wreg_eff;

    assign shamt   = ex_i.reg1[SHAMT_W-1:0];
    assign is_mult = (ex_i.alu_sel == SEL_MULT);
    assign prod    = $signed(ex_i.reg1) * $signed(ex_i.reg2);

    always_comb begin
        case (ex_i.alu_op)
            OP_AND:  logic_res = ex_i.reg1 & ex_i.reg2;
            OP_OR:   logic_res = ex_i.reg1 | ex_i.reg2;
            OP_XOR:  logic_res = ex_i.reg1 ^ ex_i.reg2;
            OP_NOR:  logic_res = ~(ex_i.reg1 | ex_i.reg2);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (ex_i.alu_op)
            OP_SLL:  shift_res = ex_i.reg2 << shamt;
            OP_SRL:  shift_res = ex_i.reg2 >> shamt;
            OP_SRA:  shift_res = $signed(ex_i.reg2) >>> shamt;
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (ex_i.alu_op)
            OP_ADD:  arith_res = ex_i.reg1 + ex_i.reg2; // wraps, no trap
            OP_SUB:  arith_res = ex_i.reg1 - ex_i.reg2;
            OP_SLT:  arith_res = {{(DATA_W-1){1'b0}},
                                  $signed(ex_i.reg1) < $signed(ex_i.reg2)};
            default: arith_res = '0;
        endcase
    end

    always_comb begin
        if (ex_i.mf_hi_lo[1]) move_res = hi_rdata_i;
        else if (ex_i.mf_hi_lo[0]) move_res = lo_rdata_i;
        else move_res = '0;
    end

    always_comb begin
        case (ex_i.alu_sel)
            SEL_LOGIC: result = logic_res;
            SEL_SHIFT: result = shift_res;
            SEL_ARITH: result = arith_res;
            SEL_MOVE:  result = move_res;
            default:   result = '0;
        endcase
    end

    // mult and move-to only touch hi/lo
    assign wreg_eff = ex_i.wreg && !is_mult && (ex_i.alu_sel != SEL_NOP)
                      && !ex_i.mt_hi && !ex_i.mt_lo;

    assign hi_we_o    = !stall_i && (is_mult || ex_i.mt_hi);
    assign lo_we_o    = !stall_i && (is_mult || ex_i.mt_lo);
    assign hi_wdata_o = is_mult ? prod[2*DATA_W-1:DATA_W] : ex_i.reg1;
    assign lo_wdata_o = is_mult ? prod[DATA_W-1:0] : ex_i.reg1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_wreg_o  <= 1'b0;
            wb_wd_o    <= '0;
            wb_wdata_o <= '0;
        end else if (!stall_i) begin
            wb_wreg_o  <= wreg_eff;
            wb_wd_o    <= ex_i.wd;
            wb_wdata_o <= result;
        end
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !stall_i |-> !$isunknown({ex_i.alu_sel, ex_i.alu_op}))
        else $error("unknown select or op at execute");

endmodule

//--- hw/exe_stage_top.sv
// execute slice top level
`timescale 1ns/1ps

module exe_stage_top
    import exe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  stall_i,

    input  alu_sel_t              id_alu_sel_i,
    input  alu_op_t               id_alu_op_i,
    input  logic [DATA_W-1:0]     id_reg1_i,
    input  logic [DATA_W-1:0]     id_reg2_i,
    input  logic                  id_wreg_i,
    input  logic [REG_ADDR_W-1:0] id_wd_i,
    input  logic                  id_mt_hi_i,
    input  logic                  id_mt_lo_i,

    output logic                  wb_wreg_o,
    output logic [REG_ADDR_W-1:0] wb_wd_o,
    output logic [DATA_W-1:0]     wb_wdata_o
);

    logic              hi_we;
    logic              lo_we;
    logic [DATA_W-1:0] hi_wdata;
    logic [DATA_W-1:0] lo_wdata;
    logic [DATA_W-1:0] hi_rdata;
    logic [DATA_W-1:0] lo_rdata;

    id_ex_if ex_bus ();

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .id_alu_sel_i (id_alu_sel_i),
        .id_alu_op_i  (id_alu_op_i),
        .id_reg1_i    (id_reg1_i),
        .id_reg2_i    (id_reg2_i),
        .id_wreg_i    (id_wreg_i),
        .id_wd_i      (id_wd_i),
        .id_mt_hi_i   (id_mt_hi_i),
        .id_mt_lo_i   (id_mt_lo_i),
        .ex_o         (ex_bus)
    );

    exe_unit u_exe_unit (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .ex_i       (ex_bus),
        .hi_rdata_i (hi_rdata),
        .lo_rdata_i (lo_rdata),
        .hi_we_o    (hi_we),
        .lo_we_o    (lo_we),
        .hi_wdata_o (hi_wdata),
        .lo_wdata_o (lo_wdata),
        .wb_wreg_o  (wb_wreg_o),
        .wb_wd_o    (wb_wd_o),
        .wb_wdata_o (wb_wdata_o)
    );

    hilo_regs u_hilo_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .hi_we_i    (hi_we),
        .lo_we_i    (lo_we),
        .hi_wdata_i (hi_wdata),
        .lo_wdata_i (lo_wdata),
        .hi_rdata_o (hi_rdata),
        .lo_rdata_o (lo_rdata)
    );

endmodule

//--- verif/tb_exe_stage.sv
// execute slice testbench
`timescale 1ns/1ps

module tb_exe_stage
    import exe_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_RANDOM      = 600;
    localparam int MIN_DATA_CHECKS = NUM_RANDOM / 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 700;

    // random pick table, entry 15 is a nop
    localparam alu_op_t OP_TAB [16] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL,
        OP_SRA, OP_ADD, OP_SUB, OP_SLT, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MULT, OP_SLL};
    localparam alu_sel_t SEL_TAB [16] = '{SEL_LOGIC, SEL_LOGIC, SEL_LOGIC, SEL_LOGIC,
        SEL_SHIFT, SEL_SHIFT, SEL_SHIFT, SEL_ARITH, SEL_ARITH, SEL_ARITH,
        SEL_MOVE, SEL_MOVE, SEL_MOVE, SEL_MOVE, SEL_MULT, SEL_NOP};

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic                  stall;
    alu_sel_t              id_alu_sel;
    alu_op_t               id_alu_op;
    logic [DATA_W-1:0]     id_reg1;
    logic [DATA_W-1:0]     id_reg2;
    logic                  id_wreg;
    logic [REG_ADDR_W-1:0] id_wd;
    logic                  id_mt_hi;
    logic                  id_mt_lo;
    logic                  wb_wreg;
    logic [REG_ADDR_W-1:0] wb_wd;
    logic [DATA_W-1:0]     wb_wdata;

    // model state
    alu_sel_t              m_sel;
    alu_op_t               m_op;
    logic [DATA_W-1:0]     m_r1;
    logic [DATA_W-1:0]     m_r2;
    logic                  m_wreg;
    logic [REG_ADDR_W-1:0] m_wd;
    logic                  m_mth;
    logic                  m_mtl;
    logic [DATA_W-1:0]     m_hi;
    logic [DATA_W-1:0]     m_lo;
    logic                  exp_wreg;
    logic [REG_ADDR_W-1:0] exp_wd;
    logic [DATA_W-1:0]     exp_wdata;

    integer seed = 32'he357;
    int     n_data_checks = 0;

    exe_stage_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .stall_i      (stall),
        .id_alu_sel_i (id_alu_sel),
        .id_alu_op_i  (id_alu_op),
        .id_reg1_i    (id_reg1),
        .id_reg2_i    (id_reg2),
        .id_wreg_i    (id_wreg),
        .id_wd_i      (id_wd),
        .id_mt_hi_i   (id_mt_hi),
        .id_mt_lo_i   (id_mt_lo),
        .wb_wreg_o    (wb_wreg),
        .wb_wd_o      (wb_wd),
        .wb_wdata_o   (wb_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] ref_result(input alu_sel_t sel, input alu_op_t op,
        input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
        input logic [DATA_W-1:0] hi, input logic [DATA_W-1:0] lo);
        logic [DATA_W-1:0] r;
        case (op)
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_NOR:  r = ~(a | b);
            OP_SLL:  r = b << a[4:0]; // shamt from operand 1
            OP_SRL:  r = b >> a[4:0];
            OP_SRA:  r = $signed(b) >>> a[4:0];
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_MFHI: r = hi;
            OP_MFLO: r = lo;
            default: r = '0;
        endcase
        if (sel == SEL_NOP || sel == SEL_MULT) r = '0;
        return r;
    endfunction

    always @(posedge clk) begin : model_step
        logic signed [2*DATA_W-1:0] p;
        if (!rst_n) begin
            {m_r1, m_r2, m_wreg, m_wd, m_mth, m_mtl, m_hi, m_lo} = '0;
            m_sel = SEL_NOP;
            m_op  = OP_SLL;
            {exp_wreg, exp_wd, exp_wdata} = '0;
        end else begin
            if (!stall) begin // writeback stage and hi/lo
                exp_wreg  = m_wreg && (m_sel != SEL_NOP) && (m_sel != SEL_MULT)
                            && !m_mth && !m_mtl;
                exp_wd    = m_wd;
                exp_wdata = ref_result(m_sel, m_op, m_r1, m_r2, m_hi, m_lo);
                if (m_sel == SEL_MULT) begin
                    p    = $signed(m_r1) * $signed(m_r2);
                    m_hi = p[2*DATA_W-1:DATA_W];
                    m_lo = p[DATA_W-1:0];
                end
                if (m_mth) m_hi = m_r1;
                if (m_mtl) m_lo = m_r1;
            end
            if (flush) begin
                {m_r1, m_r2, m_wreg, m_wd, m_mth, m_mtl} = '0;
                m_sel = SEL_NOP;
                m_op  = OP_SLL;
            end else if (!stall) begin
                m_sel  = id_alu_sel;
                m_op   = id_alu_op;
                m_r1   = id_reg1;
                m_r2   = id_reg2;
                m_wreg = id_wreg;
                m_wd   = id_wd;
                m_mth  = id_mt_hi;
                m_mtl  = id_mt_lo;
            end
        end
    end

    task automatic report_mismatch(input string what, input logic [DATA_W-1:0] got,
        input logic [DATA_W-1:0] exp);
        $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        $display("TEST FAILED");
        $fatal(1, "output mismatch");
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            assert (wb_wreg === exp_wreg)
                else report_mismatch("wb_wreg_o", DATA_W'(wb_wreg), DATA_W'(exp_wreg));
            assert (wb_wd === exp_wd)
                else report_mismatch("wb_wd_o", DATA_W'(wb_wd), DATA_W'(exp_wd));
            if (exp_wreg) begin
                n_data_checks = n_data_checks + 1;
                assert (wb_wdata === exp_wdata)
                    else report_mismatch("wb_wdata_o", wb_wdata, exp_wdata);
            end
        end
    end

    task automatic send(input alu_sel_t sel, input alu_op_t op, input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b, input logic wreg, input logic [REG_ADDR_W-1:0] wd,
        input logic st, input logic fl);
        @(posedge clk);
        id_alu_sel <= sel;
        id_alu_op  <= op;
        id_reg1    <= a;
        id_reg2    <= b;
        id_wreg    <= wreg;
        id_wd      <= wd;
        id_mt_hi   <= (op == OP_MTHI);
        id_mt_lo   <= (op == OP_MTLO);
        stall      <= st;
        flush      <= fl;
    endtask

    task automatic send_random();
        logic [31:0] r;
        logic [3:0]  idx;
        logic        wr;
        r   = $random(seed);
        idx = r[3:0];
        // moves to hi/lo never write a gpr
        wr  = (r[26:24] != 3'd0) && OP_TAB[idx] != OP_MTHI && OP_TAB[idx] != OP_MTLO;
        send(SEL_TAB[idx], OP_TAB[idx], $random(seed), $random(seed), wr,
             r[8:4], r[15:8] < 8'd26, r[23:16] < 8'd26);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n      = 1'b0;
        flush      = 1'b0;
        stall      = 1'b0;
        id_alu_sel = SEL_NOP;
        id_alu_op  = OP_SLL;
        id_reg1    = '0;
        id_reg2    = '0;
        id_wreg    = 1'b0;
        id_wd      = '0;
        id_mt_hi   = 1'b0;
        id_mt_lo   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        send(SEL_MOVE, OP_MFHI, '0, '0, 1'b1, 5'd1, 1'b0, 1'b0); // hi still 0
        send(SEL_MULT, OP_MULT, 32'hfffffff9, 32'd123456, 1'b1, 5'd2, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MFHI, '0, '0, 1'b1, 5'd3, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MFLO, '0, '0, 1'b1, 5'd4, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MTHI, 32'hdeadbeef, '0, 1'b0, 5'd5, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MTLO, 32'h12345678, '0, 1'b0, 5'd6, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MFHI, '0, '0, 1'b1, 5'd7, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MFLO, '0, '0, 1'b1, 5'd8, 1'b0, 1'b0);
        send(SEL_ARITH, OP_ADD, 32'h7fffffff, 32'd1, 1'b1, 5'd9, 1'b0, 1'b0);
        send(SEL_ARITH, OP_SLT, 32'hffffffff, 32'd1, 1'b1, 5'd10, 1'b0, 1'b0);
        send(SEL_SHIFT, OP_SRA, 32'd4, 32'h80000000, 1'b1, 5'd11, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MTHI, 32'h0badf00d, '0, 1'b0, 5'd12, 1'b0, 1'b1); // flushed
        send(SEL_MOVE, OP_MFHI, '0, '0, 1'b1, 5'd13, 1'b0, 1'b0);
        send(SEL_MULT, OP_MULT, 32'h00010000, 32'h00010000, 1'b0, 5'd14, 1'b0, 1'b0);
        repeat (3) send(SEL_LOGIC, OP_OR, 32'h5, 32'h6, 1'b1, 5'd15, 1'b1, 1'b0);
        send(SEL_MOVE, OP_MFHI, '0, '0, 1'b1, 5'd16, 1'b0, 1'b0);
        send(SEL_MOVE, OP_MFLO, '0, '0, 1'b1, 5'd17, 1'b0, 1'b0);

        repeat (NUM_RANDOM) send_random();
        repeat (4) send(SEL_NOP, OP_SLL, '0, '0, 1'b0, '0, 1'b0, 1'b0); // drain
        @(negedge clk);
        @(negedge clk);

        if (n_data_checks >= MIN_DATA_CHECKS) begin
            $display("TEST PASSED");
        end else begin
            $display("only %0d result data compares were made", n_data_checks);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
hw/exe_pkg.sv
hw/id_ex_if.sv
hw/id_ex_reg.sv
hw/hilo_regs.sv
hw/exe_unit.sv
hw/exe_stage_top.sv
verif/tb_exe_stage.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module tb_exe_stage -f project.f -o sim_exe || exit 1
./obj_dir/sim_exe > sim.log 2>&1
grep -q "TEST PASSED" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }
